//--- flist.f
hw/tm_sched_pkg.sv
hw/period_timer.sv
hw/tm_divider.sv
hw/tx_request_ctrl.sv
hw/tm_sr_gen.sv
tb/tb_clkgen.sv
tb/tb_tm_sr_gen.sv

//--- Makefile
# Verilator build and run for the telemetry scheduler testbench.

VERILATOR ?= verilator
TOP       ?= tb_tm_sr_gen
FLAGS     ?= --binary --timing --assert
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# pass or fail is taken from the simulation output.
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_tm_sr_gen.sv
`timescale 1ns/1ps

module tb_tm_sr_gen;

	localparam int pt    = tm_sched_pkg::period_ticks;
	localparam int len_1 = 20;                             // reset_idle.
	localparam int len_2 = 4 * pt + 200;                   // tm_10hz_period.
	localparam int len_3 = 21 * pt * 2;                    // tm_1hz_period.
	localparam int len_4 = 2 * (4 * pt + 100) + 22 * pt * 2; // pre_tm_window.
	localparam int len_5 = 5 * pt + 20;                    // backpressure_hold.
	localparam int len_6 = pt + 40;                        // sr_repeat_req.
	localparam int wd_cycles = (len_1 + len_2 + len_3 + len_4 + len_5 + len_6) * 11 / 10;

	logic clk;
	logic n_rst;
	tm_sched_pkg::tm_rate_e   tm_rate;
	tm_sched_pkg::link_rate_e link_rate;
	logic                     sr_repeat;
	logic                     tm_req_valid;
	tm_sched_pkg::tm_req_t    tm_req;
	logic                     tm_req_ready;
	logic                     sr_req_valid;
	tm_sched_pkg::sr_req_t    sr_req;
	logic                     sr_req_ready;
	logic                     pre_tm;

	// reference model state.
	int   cyc;
	int   m_tick;
	int   m_idx;
	logic m_win;
	logic m_tmv;
	int   m_seq;
	logic m_srv;
	logic m_rep;
	logic m_pe;
	logic m_slot;
	logic m_wen;
	int   m_warn;
	logic exp_pre;

	// monitor state.
	logic tm_v_q;
	logic sr_v_q;
	logic pre_q;
	int   pre_cnt;
	logic tm_rdy_q;
	logic sr_rdy_q;
	int   tm_rise_cyc[$];
	int   tm_rise_seq[$];
	int   sr_rise_cyc[$];
	int   pre_len[$];
	int   pre_end_tick[$];

	string cur_test;
	int    cur_err;
	int    n_pass;
	int    n_fail;

	tb_clkgen u_clkgen (
		.clk   (clk),
		.n_rst (n_rst)
	);

	tm_sr_gen DUT (
		.clk          (clk),
		.n_rst        (n_rst),
		.tm_rate      (tm_rate),
		.link_rate    (link_rate),
		.sr_repeat    (sr_repeat),
		.tm_req_valid (tm_req_valid),
		.tm_req       (tm_req),
		.tm_req_ready (tm_req_ready),
		.sr_req_valid (sr_req_valid),
		.sr_req       (sr_req),
		.sr_req_ready (sr_req_ready),
		.pre_tm       (pre_tm)
	);

	// model combinational terms, straight from the timing rules.
	assign m_pe   = (m_tick == pt - 1);
	assign m_slot = (tm_rate == tm_sched_pkg::rate_10hz) ? m_pe
		: (m_pe && m_idx == tm_sched_pkg::slots_per_second - 1);
	assign m_wen  = (tm_rate == tm_sched_pkg::rate_10hz) ? 1'b1 : m_win;
	assign m_warn = pt - 1 - int'(tm_sched_pkg::pre_margin)
		- ((link_rate == tm_sched_pkg::link_1mbps) ? int'(tm_sched_pkg::ccw_ticks_fast)
		: int'(tm_sched_pkg::ccw_ticks_slow));
	assign exp_pre = m_wen && (m_tick >= m_warn) && !m_slot;

	// reference model registers.
	always @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			cyc    <= 1;
			m_tick <= 0;
			m_idx  <= 0;
			m_win  <= 1'b0;
			m_tmv  <= 1'b0;
			m_seq  <= 0;
			m_srv  <= 1'b0;
			m_rep  <= 1'b0;
		end
		else
		begin
			cyc    <= cyc + 1;
			m_tick <= m_pe ? 0 : m_tick + 1;
			if (m_pe)
				m_idx <= (m_idx == tm_sched_pkg::slots_per_second - 1) ? 0 : m_idx + 1;
			if (m_pe && m_idx == tm_sched_pkg::slots_per_second - 1)
				m_win <= 1'b0; // slot of the tenth period.
			else if (m_idx == tm_sched_pkg::slots_per_second - 1)
				m_win <= 1'b1;
			m_tmv <= m_slot ? 1'b1 : (tm_req_ready ? 1'b0 : m_tmv); // set wins.
			m_seq <= m_slot ? (m_seq + 1) % 256 : m_seq;
			m_srv <= (m_pe || sr_repeat) ? 1'b1 : (sr_req_ready ? 1'b0 : m_srv);
			if (m_pe || sr_repeat)
				m_rep <= sr_repeat && !m_pe;
		end
	end

	// ready as seen by the DUT at the edge.
	always @(posedge clk)
	begin
		tm_rdy_q <= tm_req_ready;
		sr_rdy_q <= sr_req_ready;
	end

	task automatic report_mismatch(input string what, input int exp_v, input int act_v);
		$display("ERR %s %s expected %0d actual %0d", cur_test, what, exp_v, act_v);
		cur_err++;
	endtask

	task automatic report_problem(input string msg);
		$display("%s: %s", cur_test, msg);
		cur_err++;
	endtask

	// checks at the falling edge, where every output has settled.
	always @(negedge clk)
	begin
		if (!n_rst)
		begin
			assert (!tm_req_valid && !sr_req_valid && !pre_tm && tm_req.seq == 0)
			else report_problem("outputs are not idle while reset is asserted");
		end
		else
		begin
			assert (tm_req_valid == m_tmv)
			else report_mismatch("tm_req_valid", int'(m_tmv), int'(tm_req_valid));
			assert (int'(tm_req.seq) == m_seq)
			else report_mismatch("seq", m_seq, int'(tm_req.seq));
			assert (sr_req_valid == m_srv)
			else report_mismatch("sr_req_valid", int'(m_srv), int'(sr_req_valid));
			assert (!m_srv || sr_req.is_repeat == m_rep)
			else report_mismatch("is_repeat", int'(m_rep), int'(sr_req.is_repeat));
			assert (pre_tm == exp_pre)
			else report_mismatch("pre_tm", int'(exp_pre), int'(pre_tm));
			assert (!(tm_v_q && !tm_req_valid && !tm_rdy_q))
			else report_problem("tm_req_valid dropped without a ready cycle");
			assert (!(sr_v_q && !sr_req_valid && !sr_rdy_q))
			else report_problem("sr_req_valid dropped without a ready cycle");
			if (tm_req_valid && !tm_v_q)
			begin
				tm_rise_cyc.push_back(cyc);
				tm_rise_seq.push_back(int'(tm_req.seq));
			end
			if (sr_req_valid && !sr_v_q)
				sr_rise_cyc.push_back(cyc);
			if (pre_tm)
				pre_cnt = pre_cnt + 1;
			else if (pre_q)
			begin
				pre_len.push_back(pre_cnt); // run just ended.
				pre_end_tick.push_back(m_tick);
				pre_cnt = 0;
			end
		end
		tm_v_q = tm_req_valid;
		sr_v_q = sr_req_valid;
		pre_q  = pre_tm;
	end

	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#5;
	endtask

	task automatic clear_queues();
		tm_rise_cyc.delete();
		tm_rise_seq.delete();
		sr_rise_cyc.delete();
		pre_len.delete();
		pre_end_tick.delete();
	endtask

	task automatic wait_tm_rises(input int n, input int max_cyc);
		int k;
		k = 0;
		while (tm_rise_cyc.size() < n && k < max_cyc)
		begin
			step(1);
			k++;
		end
		if (tm_rise_cyc.size() < n)
			report_problem("telemetry request did not rise in time");
	endtask

	task automatic wait_pre_runs(input int n, input int max_cyc);
		int k;
		k = 0;
		while (pre_len.size() < n && k < max_cyc)
		begin
			step(1);
			k++;
		end
		if (pre_len.size() < n)
			report_problem("pre-telemetry warning did not appear in time");
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		cur_err  = 0;
	endtask

	task automatic end_test();
		if (cur_err == 0)
		begin
			$display("%s: PASS", cur_test);
			n_pass++;
		end
		else
		begin
			$display("%s: FAIL, %0d errors", cur_test, cur_err);
			n_fail++;
		end
	endtask

	// runs one speed at 10 hz, two warnings per speed.
	task automatic check_pre_runs(input tm_sched_pkg::link_rate_e lr, input int win);
		link_rate = lr;
		clear_queues();
		wait_tm_rises(1, 2 * pt); // sync to a period start.
		clear_queues();
		wait_pre_runs(2, 2 * pt + 100);
		foreach (pre_len[i])
		begin
			assert (pre_len[i] == win + tm_sched_pkg::pre_margin)
			else report_mismatch("pre_tm length", win + tm_sched_pkg::pre_margin, pre_len[i]);
			assert (pre_end_tick[i] == pt - 1)
			else report_mismatch("pre_tm end tick", pt - 1, pre_end_tick[i]);
		end
	endtask

	initial
	begin
		tm_rate      = tm_sched_pkg::rate_10hz;
		link_rate    = tm_sched_pkg::link_1mbps;
		sr_repeat    = 1'b0;
		tm_req_ready = 1'b1;
		sr_req_ready = 1'b1;
		tm_v_q = 1'b0;
		sr_v_q = 1'b0;
		pre_q  = 1'b0;
		pre_cnt = 0;
		n_pass = 0;
		n_fail = 0;
		void'($urandom(32'h2148_ad77));

		begin_test("reset_idle"); // idle checks run in the monitor during reset.
		while (n_rst !== 1'b1)
			@(posedge clk);
		@(negedge clk);
		assert (!tm_req_valid && !sr_req_valid && !pre_tm && tm_req.seq == 0)
		else report_problem("outputs are not idle after reset release");
		end_test();

		begin_test("tm_10hz_period");
		wait_tm_rises(3, 4 * pt);
		if (tm_rise_cyc.size() >= 3)
		begin
			assert (tm_rise_cyc[0] == pt + 1) else report_mismatch("first rise", pt + 1, tm_rise_cyc[0]);
			for (int i = 1; i < 3; i++)
			begin
				assert (tm_rise_cyc[i] - tm_rise_cyc[i - 1] == pt)
				else report_mismatch("tm spacing", pt, tm_rise_cyc[i] - tm_rise_cyc[i - 1]);
			end
			// seq starts at 0 and counts every slot since reset.
			for (int i = 0; i < 3; i++)
			begin
				assert (tm_rise_seq[i] == i + 1)
				else report_mismatch("seq at rise", i + 1, tm_rise_seq[i]);
				assert (i < sr_rise_cyc.size() && sr_rise_cyc[i] == tm_rise_cyc[i])
				else report_problem("service request rise does not match telemetry rise");
			end
		end
		end_test();

		begin_test("tm_1hz_period");
		tm_rate = tm_sched_pkg::rate_1hz;
		clear_queues();
		wait_tm_rises(2, 21 * pt * 2);
		if (tm_rise_cyc.size() >= 2)
		begin
			assert (tm_rise_cyc[1] - tm_rise_cyc[0] == 10 * pt)
			else report_mismatch("tm spacing", 10 * pt, tm_rise_cyc[1] - tm_rise_cyc[0]);
		end
		for (int i = 1; i < sr_rise_cyc.size(); i++)
		begin
			assert (sr_rise_cyc[i] - sr_rise_cyc[i - 1] == pt)
			else report_mismatch("sr spacing", pt, sr_rise_cyc[i] - sr_rise_cyc[i - 1]);
		end
		end_test();

		begin_test("pre_tm_window");
		tm_rate = tm_sched_pkg::rate_10hz;
		check_pre_runs(tm_sched_pkg::link_1mbps, tm_sched_pkg::ccw_ticks_fast);
		check_pre_runs(tm_sched_pkg::link_125kbps, tm_sched_pkg::ccw_ticks_slow);
		tm_rate   = tm_sched_pkg::rate_1hz;
		link_rate = tm_sched_pkg::link_1mbps;
		clear_queues();
		wait_tm_rises(1, 22 * pt);
		clear_queues();
		wait_tm_rises(1, 22 * pt);
		assert (pre_len.size() == 1) else report_mismatch("warnings per second", 1, pre_len.size());
		end_test();

		begin_test("backpressure_hold");
		tm_rate = tm_sched_pkg::rate_10hz;
		repeat (5 * pt)
		begin
			tm_req_ready = ($urandom % 4 == 0); // mostly stalled.
			sr_req_ready = ($urandom % 4 == 0);
			step(1);
		end
		tm_req_ready = 1'b1;
		sr_req_ready = 1'b1;
		step(4);
		end_test();

		begin_test("sr_repeat_req");
		while (m_tick != pt / 2)
			step(1);
		sr_repeat    = 1'b1;
		sr_req_ready = 1'b0;
		step(1);
		sr_repeat = 1'b0;
		@(negedge clk);
		assert (sr_req_valid) else report_mismatch("sr_req_valid", 1, int'(sr_req_valid));
		assert (sr_req.is_repeat) else report_mismatch("is_repeat", 1, int'(sr_req.is_repeat));
		step(3);
		@(negedge clk);
		assert (sr_req_valid) else report_problem("service request lost while stalled");
		step(1);
		sr_req_ready = 1'b1;
		step(1);
		@(negedge clk);
		assert (!sr_req_valid) else report_mismatch("sr_req_valid", 0, int'(sr_req_valid));
		end_test();

		$display("tests %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// watchdog, sized from the test lengths plus 10 percent.
	initial
	begin
		repeat (wd_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, run stopped", wd_cycles);
		$display("Test failures found");
		$finish;
	end

endmodule

//--- tb/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk = 1'b0,
	output logic n_rst
);

	localparam time half_period = 20ns; // 40 ns clock.
	localparam int  rst_cycles  = 10;   // reset length in cycles.

	always #(half_period) clk = ~clk; // free-running.

	// release a little after an edge, away from the sampling point.
	initial
	begin
		n_rst = 1'b0;
		repeat (rst_cycles) @(posedge clk);
		#5 n_rst = 1'b1;
	end

endmodule

//--- hw/tm_sr_gen.sv
`timescale 1ns/1ps

module tm_sr_gen (
	input  logic                     clk,
	input  logic                     n_rst,
	input  tm_sched_pkg::tm_rate_e   tm_rate,   // telemetry rate, steady per test.
	input  tm_sched_pkg::link_rate_e link_rate, // line speed, steady per test.
	input  logic                     sr_repeat, // external repeat pulse.
	output logic                     tm_req_valid,
	output tm_sched_pkg::tm_req_t    tm_req,
	input  logic                     tm_req_ready,
	output logic                     sr_req_valid,
	output tm_sched_pkg::sr_req_t    sr_req,
	input  logic                     sr_req_ready,
	output logic                     pre_tm
);

	tm_sched_pkg::timer_out_t tmr; // tick and period end.
	tm_sched_pkg::slot_out_t  slt; // slot and window enable.

	// base period timer.
	period_timer u_period_timer (
		.clk   (clk),
		.n_rst (n_rst),
		.tmr   (tmr)
	);

	// telemetry slot divider, runs beside the timer.
	tm_divider u_tm_divider (
		.clk     (clk),
		.n_rst   (n_rst),
		.tm_rate (tm_rate),
		.tmr     (tmr),
		.slt     (slt)
	);

	// request handshakes and warning.
	tx_request_ctrl u_tx_request_ctrl (
		.clk          (clk),
		.n_rst        (n_rst),
		.link_rate    (link_rate),
		.tmr          (tmr),
		.slt          (slt),
		.sr_repeat    (sr_repeat),
		.tm_req_valid (tm_req_valid),
		.tm_req       (tm_req),
		.tm_req_ready (tm_req_ready),
		.sr_req_valid (sr_req_valid),
		.sr_req       (sr_req),
		.sr_req_ready (sr_req_ready),
		.pre_tm       (pre_tm)
	);

endmodule

//--- hw/tx_request_ctrl.sv
`timescale 1ns/1ps

module tx_request_ctrl (
	input  logic                     clk,
	input  logic                     n_rst,
	input  tm_sched_pkg::link_rate_e link_rate,
	input  tm_sched_pkg::timer_out_t tmr,
	input  tm_sched_pkg::slot_out_t  slt,
	input  logic                     sr_repeat,
	output logic                     tm_req_valid,
	output tm_sched_pkg::tm_req_t    tm_req,
	input  logic                     tm_req_ready,
	output logic                     sr_req_valid,
	output tm_sched_pkg::sr_req_t    sr_req,
	input  logic                     sr_req_ready,
	output logic                     pre_tm
);

	logic                  tm_set;     // telemetry slot this cycle.
	logic                  sr_set;     // period end or repeat pulse.
	tm_sched_pkg::tm_seq_t seq_q;      // telemetry sequence counter.
	logic                  repeat_q;   // cause of the latest service request.
	tm_sched_pkg::tick_t   window;     // transfer window for the line speed.
	tm_sched_pkg::tick_t   warn_start; // first tick of the warning.

	assign tm_set = slt.slot;
	assign sr_set = tmr.period_end | sr_repeat;

	// telemetry request flag, set wins over clear.
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			tm_req_valid <= 1'b0;
		end
		else if (tm_set)
		begin
			tm_req_valid <= 1'b1; // new slot.
		end
		else if (tm_req_ready)
		begin
			tm_req_valid <= 1'b0; // accepted.
		end
	end

	// sequence number advances at each slot.
	// a slot under back-pressure still advances it, missed slots are dropped.
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			seq_q <= '0;
		end
		else if (tm_set)
		begin
			seq_q <= seq_q + tm_sched_pkg::tm_seq_t'(1); // wraps at 255.
		end
	end

	// service request flag, same handshake.
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			sr_req_valid <= 1'b0;
		end
		else if (sr_set)
		begin
			sr_req_valid <= 1'b1;
		end
		else if (sr_req_ready)
		begin
			sr_req_valid <= 1'b0;
		end
	end

	// repeat flag, period end takes precedence.
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			repeat_q <= 1'b0;
		end
		else if (sr_set)
		begin
			repeat_q <= sr_repeat & ~tmr.period_end; // 0 when both coincide.
		end
	end

	assign tm_req.seq       = seq_q;
	assign sr_req.is_repeat = repeat_q;

	// transfer window by line speed.
	always_comb
	begin
		case (link_rate)
			tm_sched_pkg::link_1mbps:   window = tm_sched_pkg::tick_t'(tm_sched_pkg::ccw_ticks_fast);
			tm_sched_pkg::link_125kbps: window = tm_sched_pkg::tick_t'(tm_sched_pkg::ccw_ticks_slow);
			default:                    window = tm_sched_pkg::tick_t'(tm_sched_pkg::ccw_ticks_slow);
		endcase
	end

	// warning opens window+pre_margin ticks before the final tick.
	assign warn_start = tm_sched_pkg::tick_t'(tm_sched_pkg::period_ticks - 1)
		- window - tm_sched_pkg::tick_t'(tm_sched_pkg::pre_margin);

	// pre-telemetry warning, drops in the slot cycle itself.
	assign pre_tm = slt.window_en & (tmr.tick >= warn_start) & ~slt.slot;

endmodule

//--- hw/tm_divider.sv
`timescale 1ns/1ps

module tm_divider (
	input  logic                     clk,
	input  logic                     n_rst,
	input  tm_sched_pkg::tm_rate_e   tm_rate,
	input  tm_sched_pkg::timer_out_t tmr,
	output tm_sched_pkg::slot_out_t  slt
);

	tm_sched_pkg::period_cnt_t idx_q;    // period index within the second.
	logic                      last_per; // running the last period.
	logic                      slot_1hz; // end of the last period.
	logic                      win_q;    // 1 hz warning enable.

	assign last_per = (idx_q == tm_sched_pkg::period_cnt_t'(tm_sched_pkg::slots_per_second - 1));
	assign slot_1hz = tmr.period_end & last_per;

	// period index, counts period ends modulo slots_per_second.
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			idx_q <= '0;
		end
		else if (slot_1hz)
		begin
			idx_q <= '0; // second complete.
		end
		else if (tmr.period_end)
		begin
			idx_q <= idx_q + tm_sched_pkg::period_cnt_t'(1);
		end
	end

	// window enable for the slow rate.
	// high through the last period, dropped after its slot.
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			win_q <= 1'b0;
		end
		else if (slot_1hz)
		begin
			win_q <= 1'b0; // slot taken, close the window.
		end
		else if (last_per)
		begin
			win_q <= 1'b1; // last period reached.
		end
	end

	// rate select.
	always_comb
	begin
		case (tm_rate)
			tm_sched_pkg::rate_10hz:
			begin
				slt.slot      = tmr.period_end; // every period.
				slt.window_en = 1'b1;           // warn before each slot.
			end
			tm_sched_pkg::rate_1hz:
			begin
				slt.slot      = slot_1hz; // every tenth period.
				slt.window_en = win_q;
			end
			default:
			begin
				slt.slot      = tmr.period_end;
				slt.window_en = 1'b1;
			end
		endcase
	end

endmodule

//--- hw/period_timer.sv
`timescale 1ns/1ps

module period_timer (
	input  logic                     clk,
	input  logic                     n_rst,
	output tm_sched_pkg::timer_out_t tmr
);

	tm_sched_pkg::tick_t tick_q;  // current tick.
	logic                at_last; // tick_q sits on the final tick.

	// final tick of the base period.
	assign at_last = (tick_q == tm_sched_pkg::tick_t'(tm_sched_pkg::period_ticks - 1));

	// free-running counter, 0 to period_ticks-1.
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			tick_q <= '0; // period starts at release.
		end
		else if (at_last)
		begin
			tick_q <= '0; // wrap to the next period.
		end
		else
		begin
			tick_q <= tick_q + tm_sched_pkg::tick_t'(1);
		end
	end

	// period end is the single last cycle.
	// downstream blocks sample it on the same edge as the wrap.
	assign tmr.tick       = tick_q;  // registered count.
	assign tmr.period_end = at_last; // one-cycle pulse.

endmodule

//--- hw/tm_sched_pkg.sv
package tm_sched_pkg;

	// one base period stands for 100 ms on the real link.
	// all cycle counts below are scaled down for simulation.
	localparam int unsigned period_ticks     = 2000; // clock cycles per base period.
	localparam int unsigned slots_per_second = 10;   // base periods per 1 hz slot.

	// control-word transfer window, 4 service + 62 data + 2 crc frames.
	localparam int unsigned ccw_ticks_fast = 150;  // window at 1 mbit/s.
	localparam int unsigned ccw_ticks_slow = 1200; // window at 125 kbit/s.
	localparam int unsigned pre_margin     = 2;    // extra lead before the window.

	typedef logic [10:0] tick_t;      // tick count within a period.
	typedef logic [3:0]  period_cnt_t; // period index within a second.
	typedef logic [7:0]  tm_seq_t;    // telemetry sequence number.

	// telemetry slot rate.
	typedef enum logic
	{
		rate_10hz, // slot at every period end.
		rate_1hz   // slot at every tenth period end.
	} tm_rate_e;

	// serial line speed, sets the warning length.
	typedef enum logic
	{
		link_1mbps,  // short transfer window.
		link_125kbps // long transfer window.
	} link_rate_e;

	// period timer result.
	typedef struct packed
	{
		tick_t tick;       // registered tick count.
		logic  period_end; // last cycle of the period.
	} timer_out_t;

	// telemetry divider result.
	typedef struct packed
	{
		logic slot;      // telemetry slot pulse.
		logic window_en; // warning allowed in this period.
	} slot_out_t;

	// telemetry request payload.
	typedef struct packed
	{
		tm_seq_t seq; // sequence number of the latest slot.
	} tm_req_t;

	// service request payload.
	typedef struct packed
	{
		logic is_repeat; // raised by the external repeat pulse only.
	} sr_req_t;

endpackage
